// ==== source/uart_rx_settings.svh ====
/*
  UART receiver settings
  baud divider, oversampling, FIFO depth, AXI4-Lite widths and register map
*/
`ifndef UART_RX_SETTINGS_SVH
`define UART_RX_SETTINGS_SVH

// baud generation
`define UART_RX_BAUD_DIV    4     // clocks per oversampling tick
`define UART_RX_OVERSAMPLE  8     // ticks per bit

// receive buffer
`define UART_RX_FIFO_DEPTH  4     // frames held, power of two

// AXI4-Lite bus
`define UART_RX_ADDR_W      4
`define UART_RX_DATA_W      32

// register offsets, sized to UART_RX_ADDR_W
`define UART_RX_REG_DATA    4'h0
`define UART_RX_REG_STATUS  4'h4
`define UART_RX_REG_CTRL    4'h8

`endif

// ==== source/uart_rx_pkg.sv ====
/*
  UART receiver types
  frame format, received frame and the AXI4-Lite request and response bundles
*/
`include "uart_rx_settings.svh"

package uart_rx_pkg;

  // field order puts bit8 at bit 0, same layout as CTRL
  typedef struct packed {
    logic odd_n_even;   // 1 = odd parity
    logic parity_en;
    logic bit8;         // 1 = 8 data bits, 0 = 7
  } uart_cfg_t;

  // same layout as the DATA register
  typedef struct packed {
    logic       framing_err;
    logic       parity_err;
    logic [7:0] data;
  } rx_frame_t;

  // master to slave
  typedef struct packed {
    logic [`UART_RX_ADDR_W-1:0]   awaddr;
    logic                         awvalid;
    logic [`UART_RX_DATA_W-1:0]   wdata;
    logic [`UART_RX_DATA_W/8-1:0] wstrb;
    logic                         wvalid;
    logic                         bready;
    logic [`UART_RX_ADDR_W-1:0]   araddr;
    logic                         arvalid;
    logic                         rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic                       awready;
    logic                       wready;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       arready;
    logic [`UART_RX_DATA_W-1:0] rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
  } axil_rsp_t;

endpackage

// ==== source/uart_rx_deserializer.sv ====
/*
  UART deserializer
  oversampling tick divider, three-sample majority filter and the frame FSM
  with start validation, 7/8 data bits, optional parity and stop check
*/
`timescale 1ns/1ps
`include "uart_rx_settings.svh"

module uart_rx_deserializer (
  input  logic                   clk,
  input  logic                   aresetn,
  input  logic                   rx,
  input  uart_rx_pkg::uart_cfg_t cfg,
  output uart_rx_pkg::rx_frame_t frame,
  output logic                   frame_valid
);

  localparam int DIV_W = $clog2(`UART_RX_BAUD_DIV);
  localparam int OS_W  = $clog2(`UART_RX_OVERSAMPLE);

  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`UART_RX_BAUD_DIV - 1);
  localparam logic [OS_W-1:0]  OS_LAST  = OS_W'(`UART_RX_OVERSAMPLE - 1);
  // fourth tick after the falling edge is taken as the middle of the start bit
  localparam logic [OS_W-1:0]  MID_TICK = OS_W'(`UART_RX_OVERSAMPLE / 2 - 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_PARITY,
    S_STOP
  } state_t;

  logic [DIV_W-1:0]       div_cnt;
  logic                   tick;
  logic [2:0]             samples;
  logic                   rx_filt;
  state_t                 state;
  logic [OS_W-1:0]        tick_cnt;
  logic [2:0]             bit_cnt;
  logic [2:0]             last_bit;
  logic                   armed;      // line seen high since the last frame
  logic                   bit_end;    // sampling tick of the current bit
  uart_rx_pkg::uart_cfg_t cfg_q;
  logic [7:0]             data_q;
  logic                   par_err;

  // --------------------------------------------------------------------------
  // tick divider and glitch filter
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      div_cnt <= '0;
      samples <= 3'b111;            // idle line level
    end
    else
    begin
      div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
      if (tick)
        samples <= {rx, samples[2:1]};
    end
  end

  assign tick = (div_cnt == DIV_LAST);

  // two of three wins
  assign rx_filt = (samples[0] & samples[1]) | (samples[0] & samples[2]) |
                   (samples[1] & samples[2]);

  // --------------------------------------------------------------------------
  // frame FSM
  // --------------------------------------------------------------------------
  assign bit_end  = (tick_cnt == OS_LAST);
  assign last_bit = cfg_q.bit8 ? 3'd7 : 3'd6;

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state    <= S_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      armed    <= 1'b0;
      cfg_q    <= '0;
    end
    else if (tick)
    begin
      case (state)
        S_IDLE:
        begin
          if (rx_filt)
            armed <= 1'b1;
          else if (armed)
          begin
            state    <= S_START;    // falling edge, tick 0
            tick_cnt <= '0;
          end
        end
        S_START:
        begin
          tick_cnt <= tick_cnt + 1'b1;
          if (tick_cnt == MID_TICK)
          begin
            if (!rx_filt)
            begin
              state    <= S_DATA;
              cfg_q    <= cfg;      // format frozen for this frame
              tick_cnt <= '0;
              bit_cnt  <= '0;
            end
            else
              state <= S_IDLE;      // glitch, not a start bit
          end
        end
        S_DATA:
        begin
          tick_cnt <= tick_cnt + 1'b1;
          if (bit_end)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == last_bit)
              state <= cfg_q.parity_en ? S_PARITY : S_STOP;
          end
        end
        S_PARITY:
        begin
          tick_cnt <= tick_cnt + 1'b1;
          if (bit_end)
            state <= S_STOP;
        end
        S_STOP:
        begin
          tick_cnt <= tick_cnt + 1'b1;
          if (bit_end)
          begin
            state <= S_IDLE;
            armed <= 1'b0;          // wait for a high line first
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // data and parity capture
  always_ff @(posedge clk)
  begin
    if (tick)
    begin
      if (state == S_START && tick_cnt == MID_TICK)
      begin
        data_q  <= '0;              // bit 7 stays 0 in 7-bit mode
        par_err <= 1'b0;
      end
      if (state == S_DATA && bit_end)
        data_q[bit_cnt] <= rx_filt; // LSB first
      // even: xor of all bits must be 0, odd: must be 1
      if (state == S_PARITY && bit_end)
        par_err <= (^data_q) ^ rx_filt ^ cfg_q.odd_n_even;
    end
  end

  // push in the stop-bit sampling clock
  assign frame_valid = tick & (state == S_STOP) & bit_end;

  always_comb
  begin
    frame.data        = data_q;
    frame.parity_err  = par_err;
    frame.framing_err = ~rx_filt;   // low stop bit
  end

endmodule

// ==== source/rx_fifo.sv ====
/*
  Receive frame FIFO
  circular buffer with occupancy count, drops a push when full and flags it
*/
`timescale 1ns/1ps
`include "uart_rx_settings.svh"

module rx_fifo #(
  parameter int DEPTH = `UART_RX_FIFO_DEPTH
) (
  input  logic                   clk,
  input  logic                   aresetn,
  input  logic                   push,
  input  uart_rx_pkg::rx_frame_t push_frame,
  input  logic                   pop,
  output uart_rx_pkg::rx_frame_t head,
  output logic                   empty,
  output logic                   full,
  output logic                   overflow
);

  localparam int PTR_W = $clog2(DEPTH);

  uart_rx_pkg::rx_frame_t mem [DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [PTR_W:0]         count;
  logic                   do_push;
  logic                   do_pop;

  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;    // wraps, DEPTH is a power of two
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_frame;
  end

  assign head     = mem[rd_ptr];
  assign empty    = (count == '0);
  assign full     = (count == (PTR_W + 1)'(DEPTH));
  assign overflow = push & full;    // frame lost

endmodule

// ==== source/axil_rx_regs.sv ====
/*
  AXI4-Lite register slave for the UART receiver
  DATA pops the head frame, STATUS holds the sticky overflow, CTRL sets format
*/
`timescale 1ns/1ps
`include "uart_rx_settings.svh"

module axil_rx_regs (
  input  logic                   clk,
  input  logic                   aresetn,
  input  uart_rx_pkg::axil_req_t axil_req,
  output uart_rx_pkg::axil_rsp_t axil_rsp,
  input  uart_rx_pkg::rx_frame_t head,
  input  logic                   empty,
  input  logic                   full,
  input  logic                   overflow,
  output logic                   pop,
  output uart_rx_pkg::uart_cfg_t cfg
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic                       wr_accept;
  logic                       rd_accept;
  logic                       bvalid;
  logic [1:0]                 bresp;
  logic                       rvalid;
  logic [1:0]                 rresp;
  logic [`UART_RX_DATA_W-1:0] rdata;
  logic [`UART_RX_DATA_W-1:0] rdata_d;
  logic [1:0]                 rresp_d;
  logic                       ovf_flag;
  logic                       status_rd;

  // one outstanding response per channel
  assign wr_accept = axil_req.awvalid & axil_req.wvalid & ~bvalid;
  assign rd_accept = axil_req.arvalid & ~rvalid;

  // --------------------------------------------------------------------------
  // write channel
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      bvalid <= 1'b0;
      bresp  <= RESP_OKAY;
      cfg    <= '{odd_n_even: 1'b0, parity_en: 1'b0, bit8: 1'b1};
    end
    else if (wr_accept)
    begin
      bvalid <= 1'b1;
      if (axil_req.awaddr == `UART_RX_REG_CTRL)
      begin
        bresp <= RESP_OKAY;
        if (axil_req.wstrb[0])
          cfg <= uart_rx_pkg::uart_cfg_t'(axil_req.wdata[2:0]);
      end
      else
        bresp <= RESP_SLVERR;       // DATA, STATUS and holes
    end
    else if (axil_req.bready)
      bvalid <= 1'b0;
  end

  // --------------------------------------------------------------------------
  // read channel
  // --------------------------------------------------------------------------
  always_comb
  begin
    rdata_d   = '0;
    rresp_d   = RESP_OKAY;
    pop       = 1'b0;
    status_rd = 1'b0;
    case (axil_req.araddr)
      `UART_RX_REG_DATA:
      begin
        if (!empty)
          rdata_d[9:0] = head;
        pop = rd_accept & ~empty;   // once per accepted read
      end
      `UART_RX_REG_STATUS:
      begin
        rdata_d[2:0] = {ovf_flag, full, ~empty};
        status_rd    = rd_accept;
      end
      `UART_RX_REG_CTRL: rdata_d[2:0] = cfg;
      default:           rresp_d = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
      rvalid <= 1'b0;
    else if (rd_accept)
      rvalid <= 1'b1;
    else if (axil_req.rready)
      rvalid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (rd_accept)
    begin
      rdata <= rdata_d;
      rresp <= rresp_d;
    end
  end

  // sticky overflow, a new overflow wins over the clearing read
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
      ovf_flag <= 1'b0;
    else if (overflow)
      ovf_flag <= 1'b1;
    else if (status_rd)
      ovf_flag <= 1'b0;
  end

  always_comb
  begin
    axil_rsp.awready = wr_accept;
    axil_rsp.wready  = wr_accept;
    axil_rsp.bresp   = bresp;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.arready = rd_accept;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = rresp;
    axil_rsp.rvalid  = rvalid;
  end

endmodule

// ==== source/uart_rx_axil.sv ====
/*
  UART receiver with AXI4-Lite access
  deserializer feeds the frame FIFO, the register slave drains it
*/
`timescale 1ns/1ps

module uart_rx_axil (
  input  logic                   clk,
  input  logic                   aresetn,
  input  logic                   rx,
  input  uart_rx_pkg::axil_req_t axil_req,
  output uart_rx_pkg::axil_rsp_t axil_rsp
);

  uart_rx_pkg::uart_cfg_t cfg;
  uart_rx_pkg::rx_frame_t frame;
  uart_rx_pkg::rx_frame_t head;
  logic                   frame_valid;
  logic                   empty;
  logic                   full;
  logic                   overflow;
  logic                   pop;

  uart_rx_deserializer deser0 (
    .clk         (clk),
    .aresetn     (aresetn),
    .rx          (rx),
    .cfg         (cfg),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  rx_fifo fifo0 (
    .clk        (clk),
    .aresetn    (aresetn),
    .push       (frame_valid),
    .push_frame (frame),
    .pop        (pop),
    .head       (head),
    .empty      (empty),
    .full       (full),
    .overflow   (overflow)
  );

  axil_rx_regs regs0 (
    .clk      (clk),
    .aresetn  (aresetn),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .head     (head),
    .empty    (empty),
    .full     (full),
    .overflow (overflow),
    .pop      (pop),
    .cfg      (cfg)
  );

endmodule

// ==== tests/uart_rx_axil_tb.sv ====
/*
  UART receiver testbench
  directed tests over the serial line and AXI4-Lite: register access,
  8-bit frames, parity, framing, FIFO overflow and glitch rejection
*/
`timescale 1ns/1ps
`include "uart_rx_settings.svh"

module uart_rx_axil_tb;

  localparam int  CLK_PERIOD = 10;
  localparam int  BIT_CLKS   = `UART_RX_BAUD_DIV * `UART_RX_OVERSAMPLE;
  localparam int  DEPTH      = `UART_RX_FIFO_DEPTH;
  localparam int  N_FRAMES   = 8 + 6 + 2 + (DEPTH + 1) + 1;
  localparam time WATCHDOG   = N_FRAMES * 12 * BIT_CLKS * CLK_PERIOD * 4;
  localparam logic [1:0] OKAY   = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;

  logic                   clk;
  logic                   aresetn;
  logic                   rx;
  uart_rx_pkg::axil_req_t axil_req;
  uart_rx_pkg::axil_rsp_t axil_rsp;
  logic [31:0]            lfsr_state = 32'hc5;

  uart_rx_axil dut0 (
    .clk      (clk),
    .aresetn  (aresetn),
    .rx       (rx),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG);
    $display("watchdog: the run timed out before all tests finished");
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp)
    begin
      $display("[FAIL] %0d ns: %s, got 0x%0h, expected 0x%0h", $time, msg, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  // galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic out;
    out        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out)
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    return out;
  endfunction

  function automatic logic [7:0] random_byte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++)
      b[i] = lfsr_bit();        // one step per bit
    return b;
  endfunction

  // parity bit as sent on the line and optionally inverted
  function automatic logic parity_bit(input logic [7:0] d, input uart_rx_pkg::uart_cfg_t fmt,
                                      input logic bad);
    logic p;
    p = fmt.odd_n_even ? ~(^d) : ^d;
    return p ^ bad;
  endfunction

  // DATA register image for a frame sent with the given options
  function automatic logic [31:0] expected_data(input logic [7:0] d,
                                                input uart_rx_pkg::uart_cfg_t fmt,
                                                input logic bad, input logic low_stop);
    logic [7:0] m;
    logic       x;
    logic       perr;
    m    = fmt.bit8 ? d : {1'b0, d[6:0]};
    x    = (^m) ^ parity_bit(m, fmt, bad);
    perr = fmt.parity_en & (fmt.odd_n_even ? ~x : x);   // even wants 0 and odd wants 1
    return {22'd0, low_stop, perr, m};
  endfunction

  task automatic axil_write(input logic [`UART_RX_ADDR_W-1:0] addr,
                            input logic [31:0] data, output logic [1:0] resp);
    @(posedge clk);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= 4'hf;
    axil_req.wvalid  <= 1'b1;
    axil_req.bready  <= 1'b1;
    @(negedge clk);
    while (!axil_rsp.awready)
      @(negedge clk);
    check(axil_rsp.wready, 1'b1, "wready together with awready");
    @(posedge clk);               // accepted here
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    @(negedge clk);
    while (!axil_rsp.bvalid)
      @(negedge clk);
    resp = axil_rsp.bresp;
    @(posedge clk);
    axil_req.bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [`UART_RX_ADDR_W-1:0] addr,
                           output logic [31:0] data, output logic [1:0] resp);
    @(posedge clk);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    axil_req.rready  <= 1'b1;
    @(negedge clk);
    while (!axil_rsp.arready)
      @(negedge clk);
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    @(negedge clk);
    while (!axil_rsp.rvalid)
      @(negedge clk);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge clk);
    axil_req.rready <= 1'b0;
  endtask

  task automatic hold_line(input logic level, input int clocks);
    @(posedge clk);
    rx <= level;
    repeat (clocks - 1) @(posedge clk);
  endtask

  // start, data LSB first, optional parity, stop, then one idle bit
  task automatic send_frame(input logic [7:0] d, input uart_rx_pkg::uart_cfg_t fmt,
                            input logic bad_parity, input logic low_stop);
    logic [7:0] m;
    m = fmt.bit8 ? d : {1'b0, d[6:0]};
    hold_line(1'b0, BIT_CLKS);
    for (int i = 0; i < (fmt.bit8 ? 8 : 7); i++)
      hold_line(m[i], BIT_CLKS);
    if (fmt.parity_en)
      hold_line(parity_bit(m, fmt, bad_parity), BIT_CLKS);
    hold_line(~low_stop, BIT_CLKS);
    hold_line(1'b1, BIT_CLKS);
  endtask

  task automatic wait_not_empty();
    logic [31:0] st;
    logic [1:0]  resp;
    st = '0;
    while (!st[0])
      axil_read(`UART_RX_REG_STATUS, st, resp);
  endtask

  task automatic set_format(input logic [2:0] fmt);
    logic [1:0] resp;
    axil_write(`UART_RX_REG_CTRL, {29'd0, fmt}, resp);
    check(resp, OKAY, "CTRL write response");
  endtask

  // send, wait, read back one frame and compare
  task automatic frame_round_trip(input logic [7:0] d, input uart_rx_pkg::uart_cfg_t fmt,
                                  input logic bad, input logic low_stop, input string msg);
    logic [31:0] rd;
    logic [1:0]  resp;
    send_frame(d, fmt, bad, low_stop);
    wait_not_empty();
    axil_read(`UART_RX_REG_DATA, rd, resp);
    check(resp, OKAY, {msg, " DATA response"});
    check(rd, expected_data(d, fmt, bad, low_stop), {msg, " DATA value"});
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic register_access();
    logic [31:0] rd;
    logic [1:0]  resp;
    axil_read(`UART_RX_REG_STATUS, rd, resp);
    check(rd, 32'd0, "STATUS after reset");
    axil_read(`UART_RX_REG_CTRL, rd, resp);
    check(rd, 32'd1, "CTRL after reset");
    set_format(3'd5);
    axil_read(`UART_RX_REG_CTRL, rd, resp);
    check(rd, 32'd5, "CTRL read back");
    set_format(3'd1);
    axil_read(4'hc, rd, resp);
    check(resp, SLVERR, "unmapped read response");
    check(rd, 32'd0, "unmapped read data");
    axil_write(`UART_RX_REG_STATUS, 32'd0, resp);
    check(resp, SLVERR, "STATUS write response");
  endtask

  task automatic eight_bit_frames();
    logic [31:0] rd;
    logic [1:0]  resp;
    for (int i = 0; i < 8; i++)
    begin
      frame_round_trip(random_byte(), 3'b001, 1'b0, 1'b0, "8N1");
      axil_read(`UART_RX_REG_STATUS, rd, resp);
      check(rd, 32'd0, "STATUS empty after 8N1 read");
    end
  endtask

  task automatic parity_frames();
    logic [2:0] fmts [3];
    fmts[0] = 3'b010;             // 7 bits even
    fmts[1] = 3'b110;             // 7 bits odd
    fmts[2] = 3'b111;             // 8 bits odd
    for (int f = 0; f < 3; f++)
    begin
      set_format(fmts[f]);
      for (int bad = 0; bad < 2; bad++)
        frame_round_trip(random_byte(), fmts[f], bad[0], 1'b0, "parity");
    end
    set_format(3'd1);
  endtask

  task automatic framing_error_frame();
    frame_round_trip(random_byte(), 3'b001, 1'b0, 1'b1, "low stop");
    hold_line(1'b1, 2 * BIT_CLKS);
    frame_round_trip(random_byte(), 3'b001, 1'b0, 1'b0, "after low stop");
  endtask

  task automatic fifo_overflow();
    logic [7:0]  sent [DEPTH + 1];
    logic [31:0] rd;
    logic [1:0]  resp;
    for (int i = 0; i <= DEPTH; i++)
    begin
      sent[i] = random_byte();
      send_frame(sent[i], 3'b001, 1'b0, 1'b0);
    end
    axil_read(`UART_RX_REG_STATUS, rd, resp);
    check(rd, 32'd7, "STATUS full with overflow");
    axil_read(`UART_RX_REG_STATUS, rd, resp);
    check(rd, 32'd3, "STATUS overflow cleared by read");
    for (int i = 0; i < DEPTH; i++)
    begin
      axil_read(`UART_RX_REG_DATA, rd, resp);
      check(rd, {24'd0, sent[i]}, "DATA order after overflow");
    end
    axil_read(`UART_RX_REG_STATUS, rd, resp);
    check(rd, 32'd0, "STATUS empty after drain");
  endtask

  task automatic glitch_rejection();
    logic [31:0] rd;
    logic [1:0]  resp;
    hold_line(1'b0, `UART_RX_BAUD_DIV);    // one tick wide
    hold_line(1'b1, 2 * BIT_CLKS);
    axil_read(`UART_RX_REG_STATUS, rd, resp);
    check(rd, 32'd0, "no frame from glitch");
    frame_round_trip(random_byte(), 3'b001, 1'b0, 1'b0, "after glitch");
    axil_read(`UART_RX_REG_STATUS, rd, resp);
    check(rd, 32'd0, "exactly one frame after glitch");
  endtask

  initial
  begin
    aresetn  = 1'b0;
    rx       = 1'b1;              // idle line
    axil_req = '0;
    repeat (16) @(posedge clk);
    aresetn <= 1'b1;
    hold_line(1'b1, BIT_CLKS);
    register_access();
    eight_bit_frames();
    parity_frames();
    framing_error_frame();
    fifo_overflow();
    glitch_rejection();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== uart_rx_axil.f ====
+incdir+source
source/uart_rx_pkg.sv
source/uart_rx_deserializer.sv
source/rx_fifo.sv
source/axil_rx_regs.sv
source/uart_rx_axil.sv
tests/uart_rx_axil_tb.sv

// ==== Bender.yml ====
package:
  name: uart_rx_axil

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/uart_rx_pkg.sv
      - source/uart_rx_deserializer.sv
      - source/rx_fifo.sv
      - source/axil_rx_regs.sv
      - source/uart_rx_axil.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/uart_rx_axil_tb.sv
